// ==== src/stream_buffer_pkg.sv ====
// shared widths, sizes and encodings for the burst buffer
package stream_buffer_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int data_w       = 8;               // one stream byte
  localparam int fifo_depth   = 16;              // fifo entries
  localparam int level_w      = 5;               // holds 0 .. fifo_depth
  localparam int thresh_reset = fifo_depth / 2;  // threshold out of reset

  // --------------------------------------------------
  // register map
  // --------------------------------------------------
  // ctrl bit 0 is enable
  // ctrl bit 1 is a write-one flush pulse and reads back as 0
  // thresh is read/write, 5 bits wide
  // level is read only
  // drops reads the overflow count and any write clears it
  typedef enum logic [1:0] {
    reg_ctrl   = 2'd0,
    reg_thresh = 2'd1,
    reg_level  = 2'd2,
    reg_drops  = 2'd3
  } reg_addr_e;

  // --------------------------------------------------
  // drain controller states
  // --------------------------------------------------
  typedef enum logic {
    drain_idle  = 1'b0,  // waiting for threshold or flush
    drain_burst = 1'b1   // reading one byte per cycle
  } drain_state_e;

  // bit positions inside ctrl
  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_flush_bit  = 1;

endpackage

// ==== src/fifo.sv ====
`timescale 1ns/1ps

// single clock fifo, first-word-fall-through read side
module fifo
  import stream_buffer_pkg::*;
#(
  parameter int depth = fifo_depth,
  parameter int width = data_w
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [width-1:0]   din,
  input  logic               wr_en,
  input  logic               rd_en,
  output logic [width-1:0]   dout,
  output logic               full,
  output logic               empty,
  output logic               nearly_empty,
  output logic [level_w-1:0] level,
  output logic               overflow
);

  localparam int aw = $clog2(depth);  // address bits, pointers carry one more

  logic [aw:0]      wr_ptr;   // msb is the wrap bit
  logic [aw:0]      rd_ptr;   // msb is the wrap bit
  logic [aw-1:0]    wr_loc;
  logic [aw-1:0]    rd_loc;
  logic             wr_ok;    // write accepted this cycle
  logic             rd_ok;    // read accepted this cycle
  logic [width-1:0] mem [depth];

  assign wr_loc = wr_ptr[aw-1:0];
  assign rd_loc = rd_ptr[aw-1:0];

  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // --------------------------------------------------
  // pointers
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // status
  // --------------------------------------------------
  // equal pointers mean empty
  assign empty = (wr_ptr == rd_ptr);
  // same address with the wrap bits apart means full
  assign full  = (wr_loc == rd_loc) && (wr_ptr[aw] != rd_ptr[aw]);

  assign level        = level_w'(wr_ptr - rd_ptr);  // wraps cleanly
  assign nearly_empty = (level == level_w'(1));     // exactly one held
  assign overflow     = wr_en && full;              // attempt is dropped

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_loc] <= din;
    end
  end

  assign dout = mem[rd_loc];  // head entry always visible

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_full_empty: assert property (@(posedge clk) disable iff (reset)
    !(full && empty));

  a_no_wr_when_full: assert property (@(posedge clk) disable iff (reset)
    full |=> $stable(wr_ptr));

endmodule

// ==== src/buffer_regs.sv ====
`timescale 1ns/1ps

// config and status registers beside the fifo and drain logic
module buffer_regs
  import stream_buffer_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               cfg_wr,
  input  reg_addr_e          cfg_addr,
  input  logic [data_w-1:0]  cfg_wdata,
  input  logic [level_w-1:0] level,
  input  logic               overflow,
  output logic [data_w-1:0]  cfg_rdata,
  output logic               enable,
  output logic [level_w-1:0] thresh,
  output logic               flush
);

  logic [data_w-1:0] drops;       // saturating overflow count
  logic              drops_full;  // count stuck at 255

  assign drops_full = (drops == '1);

  // --------------------------------------------------
  // writes
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      enable <= 1'b0;
      thresh <= level_w'(thresh_reset);
      flush  <= 1'b0;
      drops  <= '0;
    end else begin
      flush <= 1'b0;  // pulse by default
      if (cfg_wr && cfg_addr == reg_ctrl) begin
        enable <= cfg_wdata[ctrl_enable_bit];
        // back-to-back requests merge into one pulse
        flush  <= cfg_wdata[ctrl_flush_bit] && !flush;
      end
      if (cfg_wr && cfg_addr == reg_thresh) begin
        thresh <= cfg_wdata[level_w-1:0];
      end
      // clear wins over a same-cycle overflow
      if (cfg_wr && cfg_addr == reg_drops) begin
        drops <= '0;
      end else if (overflow && !drops_full) begin
        drops <= drops + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // read mux, combinational
  // --------------------------------------------------
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      reg_ctrl:   cfg_rdata[ctrl_enable_bit] = enable;  // flush bit reads 0
      reg_thresh: cfg_rdata = data_w'(thresh);
      reg_level:  cfg_rdata = data_w'(level);
      reg_drops:  cfg_rdata = drops;
      default:    cfg_rdata = '0;
    endcase
  end

  // flush never stretches past a single cycle
  a_flush_pulse: assert property (@(posedge clk) disable iff (reset)
    flush |=> !flush);

endmodule

// ==== src/burst_drain.sv ====
`timescale 1ns/1ps

// drains the fifo in bursts once threshold or flush says so
module burst_drain
  import stream_buffer_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               enable,
  input  logic [level_w-1:0] thresh,
  input  logic               flush,
  input  logic [level_w-1:0] level,
  input  logic               empty,
  input  logic               nearly_empty,
  input  logic [data_w-1:0]  dout,
  output logic               rd_en,
  output logic [data_w-1:0]  out_data,
  output logic               out_valid,
  output logic               out_last
);

  drain_state_e state;
  drain_state_e state_nxt;
  logic         flush_pend;  // latched flush request
  logic         start;       // idle to burst
  logic         burst_end;   // burst finishes this cycle
  logic         last_rd;     // read of the final held byte

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  assign start = enable && !empty && ((level >= thresh) || flush_pend || flush);

  assign rd_en   = (state == drain_burst) && !empty;  // one byte per cycle
  assign last_rd = rd_en && nearly_empty;

  // ends on the nearly empty read or on an empty fifo
  assign burst_end = (state == drain_burst) && (last_rd || empty);

  always_comb begin
    state_nxt = state;
    case (state)
      drain_idle:  if (start) state_nxt = drain_burst;
      drain_burst: if (burst_end) state_nxt = drain_idle;
      default:     state_nxt = drain_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= drain_idle;
      flush_pend <= 1'b0;
    end else begin
      state <= state_nxt;
      if (flush) begin
        flush_pend <= 1'b1;  // new request beats the clear
      end else if (burst_end) begin
        flush_pend <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // output stage, one cycle behind rd_en
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= rd_en;
      out_last  <= last_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      out_data <= dout;  // head byte before the pointer moves
    end
  end

  // reads only while the fifo level shows a held byte
  a_rd_not_empty: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> (level != '0));

  a_last_valid: assert property (@(posedge clk) disable iff (reset)
    out_last |-> out_valid);

endmodule

// ==== src/stream_buffer_top.sv ====
`timescale 1ns/1ps

// byte stream burst buffer, fifo plus regs plus drain controller
module stream_buffer_top
  import stream_buffer_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [data_w-1:0] in_data,
  input  logic              in_valid,
  input  logic              cfg_wr,
  input  reg_addr_e         cfg_addr,
  input  logic [data_w-1:0] cfg_wdata,
  output logic [data_w-1:0] cfg_rdata,
  output logic [data_w-1:0] out_data,
  output logic              out_valid,
  output logic              out_last,
  output logic              full,
  output logic              empty
);

  // --------------------------------------------------
  // internal nets
  // --------------------------------------------------
  logic [data_w-1:0]  fifo_dout;     // head byte
  logic               nearly_empty;
  logic [level_w-1:0] level;         // fill level
  logic               overflow;      // dropped write
  logic               rd_en;
  logic               enable;
  logic [level_w-1:0] thresh;
  logic               flush;         // one cycle pulse

  // the fifo alone decides whether a write lands
  fifo #(
    .depth (fifo_depth),
    .width (data_w)
  ) i_fifo (
    .clk          (clk),
    .reset        (reset),
    .din          (in_data),
    .wr_en        (in_valid),
    .rd_en        (rd_en),
    .dout         (fifo_dout),
    .full         (full),
    .empty        (empty),
    .nearly_empty (nearly_empty),
    .level        (level),
    .overflow     (overflow)
  );

  buffer_regs i_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .level     (level),
    .overflow  (overflow),
    .cfg_rdata (cfg_rdata),
    .enable    (enable),
    .thresh    (thresh),
    .flush     (flush)
  );

  burst_drain i_drain (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .thresh       (thresh),
    .flush        (flush),
    .level        (level),
    .empty        (empty),
    .nearly_empty (nearly_empty),
    .dout         (fifo_dout),
    .rd_en        (rd_en),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_last     (out_last)
  );

endmodule

// ==== test/tb_stream_buffer.sv ====
`timescale 1ns/1ps

module tb_stream_buffer
  import stream_buffer_pkg::*;
;

  logic              clk = 1'b0;
  logic              reset;
  logic [data_w-1:0] in_data;
  logic              in_valid;
  logic              cfg_wr;
  reg_addr_e         cfg_addr;
  logic [data_w-1:0] cfg_wdata;
  logic [data_w-1:0] cfg_rdata;
  logic [data_w-1:0] out_data;
  logic              out_valid;
  logic              out_last;
  logic              full;
  logic              empty;

  logic [data_w-1:0] model_q[$];  // bytes expected out, in order
  logic              pend_valid;  // write landed this edge, joins the queue next edge
  logic [data_w-1:0] pend_data;
  logic [data_w-1:0] exp_byte;
  int drop_offers, out_count, last_count, errors, checks, tests, err_mark;
  string cur_test;

  stream_buffer_top i_dut (.*);

  always #20 clk = ~clk;  // 40 ns period

  // saturating drop count for writes offered while full
  function automatic int expected_drops(input int offers);
    if (offers > 255) return 255;
    return offers;
  endfunction

  // --------------------------------------------------
  // model and compare, sampled at the rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      model_q.delete();
      pend_valid = 1'b0;
      drop_offers = 0;
    end else begin
      if (out_valid) begin  // read was made one edge earlier
        out_count++;
        if (out_last) last_count++;
        if (model_q.size() == 0) begin
          errors++;
          $display("error %s: output byte 0x%02h with an empty model", cur_test, out_data);
        end else begin
          exp_byte = model_q.pop_front();
          checks++;
          if (out_data !== exp_byte) begin
            errors++;
            $display("error %s out_data: expected 0x%02h, actual 0x%02h",
                     cur_test, exp_byte, out_data);
          end
          // last means the read emptied what had landed before it
          if (out_last !== (model_q.size() == 0)) begin
            errors++;
            $display("error %s out_last: expected %0b, actual %0b",
                     cur_test, model_q.size() == 0, out_last);
          end
        end
      end
      if (pend_valid) model_q.push_back(pend_data);
      // queue now matches the fifo level before this edge
      pend_valid = in_valid && (model_q.size() < fifo_depth);
      pend_data  = in_data;
      if (cfg_wr && cfg_addr == reg_drops) drop_offers = 0;  // clear wins
      else if (in_valid && model_q.size() >= fifo_depth) drop_offers++;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic check(input string what, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [data_w-1:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  task automatic check_reg(input string what, input reg_addr_e addr, input int exp);
    @(negedge clk);
    cfg_addr = addr;
    #5;  // combinational read settles well before the edge
    check(what, exp, int'(cfg_rdata));
  endtask

  task automatic send_bytes(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      in_valid = 1'b1;
      in_data  = data_w'($urandom);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  function automatic bit drained();
    return model_q.size() == 0 && !pend_valid && empty && !out_valid;
  endfunction

  task automatic wait_drained(input int limit);
    for (int n = 0; n < limit && !drained(); n++) @(negedge clk);
    if (!drained()) begin
      errors++;
      $display("timeout in %s: the buffer never drained", cur_test);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err_mark) $display("test %s ok", cur_test);
    else $display("test %s failed with %0d errors", cur_test, errors - err_mark);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int base, lbase;
    void'($urandom(32'hac0f_03fc));
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    cfg_wr = 1'b0;
    cfg_addr = reg_ctrl;
    cfg_wdata = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start_test("reset_state");
    check_reg("ctrl", reg_ctrl, 0);
    check_reg("thresh", reg_thresh, 8);
    check_reg("level", reg_level, 0);
    check_reg("drops", reg_drops, 0);
    base = out_count;
    for (int n = 0; n < 10; n++) @(negedge clk);  // idle watch
    check("idle outputs", 0, out_count - base);
    check("empty", 1, int'(empty));
    end_test();

    start_test("threshold_burst");
    reg_write(reg_thresh, 8'd4);
    reg_write(reg_ctrl, 8'h01);
    base = out_count;
    lbase = last_count;
    send_bytes(4);
    wait_drained(100);
    check("bytes out", 4, out_count - base);
    check("last flags", 1, last_count - lbase);
    check_reg("level", reg_level, 0);
    end_test();

    start_test("hold_and_flush");
    reg_write(reg_thresh, 8'd8);
    base = out_count;
    lbase = last_count;
    send_bytes(3);
    for (int n = 0; n < 40; n++) @(negedge clk);  // below thresh, nothing moves
    check("held bytes out", 0, out_count - base);
    reg_write(reg_ctrl, 8'h03);  // enable plus flush
    wait_drained(100);
    check("bytes out", 3, out_count - base);
    check("last flags", 1, last_count - lbase);
    end_test();

    start_test("overflow");
    reg_write(reg_ctrl, 8'h00);
    base = out_count;
    send_bytes(20);
    check("full", 1, int'(full));
    check_reg("level", reg_level, 16);
    check_reg("drops", reg_drops, expected_drops(drop_offers));
    reg_write(reg_thresh, 8'd16);
    reg_write(reg_ctrl, 8'h01);
    wait_drained(200);
    check("bytes out", 16, out_count - base);
    end_test();

    start_test("drop_clear");
    reg_write(reg_drops, 8'h00);
    check_reg("drops cleared", reg_drops, 0);
    reg_write(reg_ctrl, 8'h00);
    send_bytes(18);
    check_reg("drops recount", reg_drops, expected_drops(drop_offers));
    reg_write(reg_ctrl, 8'h03);
    wait_drained(200);
    end_test();

    start_test("random_traffic");
    reg_write(reg_thresh, data_w'($urandom_range(16, 1)));
    reg_write(reg_ctrl, 8'h01);
    for (int cyc = 0; cyc < 300; cyc++) begin
      @(negedge clk);
      // write only while the model says the byte is sure to land
      in_valid = ($urandom_range(1, 0) == 1) && (model_q.size() + int'(pend_valid) < fifo_depth);
      if (in_valid && full) begin
        errors++;
        $display("error %s: write offered while the fifo was full", cur_test);
      end
      in_data  = data_w'($urandom);
      cfg_wr   = 1'b0;
      if ($urandom_range(31, 0) == 0) begin  // occasional config change
        cfg_wr = 1'b1;
        if ($urandom_range(1, 0) == 0) begin
          cfg_addr  = reg_thresh;
          cfg_wdata = data_w'($urandom_range(16, 1));
        end else begin
          cfg_addr  = reg_ctrl;
          cfg_wdata = 8'h03;  // stay enabled, flush
        end
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    cfg_wr   = 1'b0;
    reg_write(reg_ctrl, 8'h03);  // final flush
    wait_drained(200);
    check("model left over", 0, model_q.size());
    check_reg("drops", reg_drops, expected_drops(drop_offers));
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
src/stream_buffer_pkg.sv
src/fifo.sv
src/buffer_regs.sv
src/burst_drain.sv
src/stream_buffer_top.sv
test/tb_stream_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_stream_buffer
FILELIST  ?= filelist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
